// File: source/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // data memory size in 32-bit words
    localparam int MEM_WORDS = 256;
    localparam int MEM_INDEX_W = 8;

    // address bits above the word index and byte offset
    localparam int MEM_HIGH_W = 32 - MEM_INDEX_W - 2;

    // parallel output region
    localparam logic [31:0] IO_BASE = 32'h8000_0000;
    localparam int IO_TAG_W = 20;
    localparam logic [IO_TAG_W-1:0] IO_TAG = IO_BASE[31:32-IO_TAG_W];

    // register select of the output latch inside the io region
    localparam logic [1:0] IO_REG_OUT = 2'd0;

    // decoded target of a transfer
    typedef enum logic [1:0] {
        REGION_MEM  = 2'd0,
        REGION_IO   = 2'd1,
        REGION_NONE = 2'd2
    } region_e;

    // memory view with the word index below the high bits
    typedef struct packed {
        logic [MEM_HIGH_W-1:0]  high;
        logic [MEM_INDEX_W-1:0] index;
        logic [1:0]             offset;
    } mem_view_t;

    // io view with the tag on top and the register select at the bottom
    typedef struct packed {
        logic [IO_TAG_W-1:0]       tag;
        logic [32-IO_TAG_W-2-1:0]  unused;
        logic [1:0]                reg_sel;
    } io_view_t;

    // one bus address seen through both decoders
    typedef union packed {
        mem_view_t mem_view;
        io_view_t  io_view;
    } bus_addr_u;

endpackage

`default_nettype wire

// File: source/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  wire                   core_clk,
    input  wire                   rst,
    input  wire                   req,
    input  wire                   wen,
    input  wire  [31:0]           addr,
    input  wire  [31:0]           wdata,
    input  wire  [3:0]            wmask,
    output logic                  cmd_valid,
    output soc_bus_pkg::region_e  cmd_region,
    output logic                  cmd_wen,
    output logic [7:0]            cmd_index,
    output logic [1:0]            cmd_reg_sel,
    output logic [31:0]           cmd_wdata,
    output logic [3:0]            cmd_wmask
);

    soc_bus_pkg::bus_addr_u addr_u;
    soc_bus_pkg::region_e   region;
    logic                   req_q;
    logic                   req_rise;

    // same address word, read through both views
    assign addr_u = addr;

    // a new request starts on the low to high edge of req
    assign req_rise = req & ~req_q;

    always_comb begin
        if (addr_u.mem_view.high == '0) begin
            region = soc_bus_pkg::REGION_MEM;
        end else if (addr_u.io_view.tag == soc_bus_pkg::IO_TAG &&
                     addr_u.io_view.reg_sel == soc_bus_pkg::IO_REG_OUT) begin
            region = soc_bus_pkg::REGION_IO;
        end else begin
            region = soc_bus_pkg::REGION_NONE;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rst) begin
            req_q     <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            req_q     <= req;
            cmd_valid <= req_rise;
        end
    end

    // command fields, held until the next request
    always_ff @(posedge core_clk) begin
        if (req_rise) begin
            cmd_region  <= region;
            cmd_wen     <= wen;
            cmd_index   <= addr_u.mem_view.index;
            cmd_reg_sel <= addr_u.io_view.reg_sel;
            cmd_wdata   <= wdata;
            cmd_wmask   <= wmask;
        end
    end

    // one command per request, even with req held high
    a_single_cmd: assert property (
        @(posedge core_clk) disable iff (rst)
        cmd_valid |=> !cmd_valid
    );

endmodule

`default_nettype wire

// File: source/bus_execute.sv
`timescale 1ns/1ps
`default_nettype none

module bus_execute (
    input  wire                  core_clk,
    input  wire                  rst,
    input  wire                  cmd_valid,
    input  wire soc_bus_pkg::region_e cmd_region,
    input  wire                  cmd_wen,
    input  wire                  mem_done,
    input  wire  [31:0]          mem_rdata,
    input  wire                  io_done,
    input  wire  [31:0]          io_rdata,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output logic                 io_ren,
    output logic                 io_wen,
    output logic                 rsp_valid,
    output logic [31:0]          rsp_rdata,
    output logic                 rsp_err
);

    // fsm state, low is idle and high is wait-done
    logic        state_wait;
    logic        sel_io;
    logic        err_q;
    logic        sel_done;
    logic [31:0] sel_rdata;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            state_wait <= 1'b0;
            sel_io     <= 1'b0;
            err_q      <= 1'b0;
            mem_ren    <= 1'b0;
            mem_wen    <= 1'b0;
            io_ren     <= 1'b0;
            io_wen     <= 1'b0;
        end else begin
            // strobes and the error response last one cycle
            mem_ren <= 1'b0;
            mem_wen <= 1'b0;
            io_ren  <= 1'b0;
            io_wen  <= 1'b0;
            err_q   <= 1'b0;
            if (!state_wait) begin
                if (cmd_valid) begin
                    case (cmd_region)
                        soc_bus_pkg::REGION_MEM: begin
                            mem_ren    <= ~cmd_wen;
                            mem_wen    <= cmd_wen;
                            sel_io     <= 1'b0;
                            state_wait <= 1'b1;
                        end
                        soc_bus_pkg::REGION_IO: begin
                            io_ren     <= ~cmd_wen;
                            io_wen     <= cmd_wen;
                            sel_io     <= 1'b1;
                            state_wait <= 1'b1;
                        end
                        default: begin
                            // unmapped, answer without touching a device
                            err_q <= 1'b1;
                        end
                    endcase
                end
            end else if (sel_done) begin
                state_wait <= 1'b0;
            end
        end
    end

    assign sel_done  = sel_io ? io_done : mem_done;
    assign sel_rdata = sel_io ? io_rdata : mem_rdata;

    // device done passes straight through in the same cycle
    assign rsp_valid = err_q | (state_wait & sel_done);
    assign rsp_rdata = state_wait ? sel_rdata : 32'd0;
    assign rsp_err   = err_q;

    a_one_strobe: assert property (
        @(posedge core_clk) disable iff (rst)
        $onehot0({mem_ren, mem_wen, io_ren, io_wen})
    );

    // a device only answers a strobe this fsm issued
    a_no_stray_done: assert property (
        @(posedge core_clk) disable iff (rst)
        !state_wait |-> !(mem_done || io_done)
    );

endmodule

`default_nettype wire

// File: source/word_memory.sv
`timescale 1ns/1ps
`default_nettype none

module word_memory (
    input  wire                                 core_clk,
    input  wire                                 ren,
    input  wire                                 wen,
    input  wire  [soc_bus_pkg::MEM_INDEX_W-1:0] index,
    input  wire  [31:0]                         wdata,
    input  wire  [3:0]                          wmask,
    output logic [31:0]                         rdata,
    output logic                                done
);

    logic [31:0] mem [soc_bus_pkg::MEM_WORDS];

    // byte lanes written only where the mask is set
    always_ff @(posedge core_clk) begin
        if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge core_clk) begin
        if (ren) begin
            rdata <= mem[index];
        end
    end

    // done is the strobe delayed by one cycle
    always_ff @(posedge core_clk) begin
        done <= ren | wen;
    end

endmodule

`default_nettype wire

// File: source/parallel_output.sv
`timescale 1ns/1ps
`default_nettype none

module parallel_output (
    input  wire         core_clk,
    input  wire         rst,
    input  wire         ren,
    input  wire         wen,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wmask,
    output logic [31:0] rdata,
    output logic        done,
    output logic [31:0] io
);

    logic [31:0] out_q;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            out_q <= 32'd0;
            done  <= 1'b0;
        end else begin
            done <= ren | wen;
            if (wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) begin
                        out_q[8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // read back of the latch as it was before this cycle
    always_ff @(posedge core_clk) begin
        if (ren) begin
            rdata <= out_q;
        end
    end

    // pins follow the latch directly
    assign io = out_q;

endmodule

`default_nettype wire

// File: source/bus_result.sv
`timescale 1ns/1ps
`default_nettype none

module bus_result (
    input  wire         core_clk,
    input  wire         rst,
    input  wire         req,
    input  wire         rsp_valid,
    input  wire  [31:0] rsp_rdata,
    input  wire         rsp_err,
    output logic        ack,
    output logic [31:0] rdata,
    output logic        err
);

    // ack half of the four-phase handshake
    always_ff @(posedge core_clk) begin
        if (rst) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else if (rsp_valid) begin
            ack <= 1'b1;
            err <= rsp_err;
        end else if (!req) begin
            // host has let go, release ack
            ack <= 1'b0;
        end
    end

    // response data held while the host stalls with req high
    always_ff @(posedge core_clk) begin
        if (rsp_valid) begin
            rdata <= rsp_rdata;
        end
    end

    // the response answers a request still being held
    a_ack_under_req: assert property (
        @(posedge core_clk) disable iff (rst)
        $rose(ack) |-> $past(req)
    );

    // no second response while the host stalls
    a_ack_stable: assert property (
        @(posedge core_clk) disable iff (rst)
        ack && req |=> ack && $stable(rdata) && $stable(err)
    );

endmodule

`default_nettype wire

// File: source/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  wire         core_clk,
    input  wire         rst,
    input  wire         req,
    input  wire         wen,
    input  wire  [31:0] addr,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wmask,
    output logic        ack,
    output logic [31:0] rdata,
    output logic        err,
    output logic [31:0] io
);

    logic                 cmd_valid;
    soc_bus_pkg::region_e cmd_region;
    logic                 cmd_wen;
    logic [7:0]           cmd_index;
    logic [31:0]          cmd_wdata;
    logic [3:0]           cmd_wmask;

    logic                 mem_ren;
    logic                 mem_wen;
    logic                 mem_done;
    logic [31:0]          mem_rdata;
    logic                 io_ren;
    logic                 io_wen;
    logic                 io_done;
    logic [31:0]          io_rdata;

    logic                 rsp_valid;
    logic [31:0]          rsp_rdata;
    logic                 rsp_err;

    // register select is already folded into cmd_region
    bus_decode decode (
        .core_clk    (core_clk),
        .rst         (rst),
        .req         (req),
        .wen         (wen),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .cmd_valid   (cmd_valid),
        .cmd_region  (cmd_region),
        .cmd_wen     (cmd_wen),
        .cmd_index   (cmd_index),
        .cmd_reg_sel (),
        .cmd_wdata   (cmd_wdata),
        .cmd_wmask   (cmd_wmask)
    );

    bus_execute execute (
        .core_clk   (core_clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_region (cmd_region),
        .cmd_wen    (cmd_wen),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .io_done    (io_done),
        .io_rdata   (io_rdata),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .io_ren     (io_ren),
        .io_wen     (io_wen),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err)
    );

    word_memory mem (
        .core_clk (core_clk),
        .ren      (mem_ren),
        .wen      (mem_wen),
        .index    (cmd_index),
        .wdata    (cmd_wdata),
        .wmask    (cmd_wmask),
        .rdata    (mem_rdata),
        .done     (mem_done)
    );

    parallel_output pp (
        .core_clk (core_clk),
        .rst      (rst),
        .ren      (io_ren),
        .wen      (io_wen),
        .wdata    (cmd_wdata),
        .wmask    (cmd_wmask),
        .rdata    (io_rdata),
        .done     (io_done),
        .io       (io)
    );

    bus_result result (
        .core_clk  (core_clk),
        .rst       (rst),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .ack       (ack),
        .rdata     (rdata),
        .err       (err)
    );

endmodule

`default_nettype wire

// File: dv/soc_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb;

    // init fill, masked writes and reads, io, unmapped, mixed
    localparam int N_TRANSFERS = 256 + 32 + 32 + 16 + 16 + 200;
    localparam int TIMEOUT_CYCLES = 40 * N_TRANSFERS + 100;

    logic        core_clk;
    logic        rst;
    logic        req;
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;
    wire         ack;
    wire  [31:0] rdata;
    wire         err;
    wire  [31:0] io;

    logic [31:0] lcg_state = 32'd45;
    logic [31:0] shadow_mem [soc_bus_pkg::MEM_WORDS];
    logic [31:0] shadow_io = 32'd0;
    logic [31:0] exp_rdata_q [$];
    logic        exp_rd_used_q [$];
    logic        exp_err_q [$];
    logic [31:0] exp_io_q [$];
    logic [31:0] obs_rdata_q [$];
    logic        obs_err_q [$];
    logic [31:0] obs_io_q [$];
    int          checked = 0;
    int          cycles = 0;
    logic        ack_prev = 1'b0;
    logic        req_prev = 1'b0;

    soc_bus_top UUT (.*);

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    // upper halves of two lcg steps since the low bits repeat quickly
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand32();
        return int'(r % 32'(n));
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] m);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                res[8*b +: 8] = d[8*b +: 8];
            end
        end
        return res;
    endfunction

    // kind 0 is memory word idx, kind 1 the output latch, kind 2 unmapped
    function automatic logic [31:0] make_addr(input int kind, input logic [7:0] idx);
        logic [31:0] r;
        logic [31:0] a;
        r = rand32();
        if (kind == 0) begin
            a = {22'd0, idx, r[1:0]};
        end else if (kind == 1) begin
            a = soc_bus_pkg::IO_BASE | {20'd0, r[11:2], soc_bus_pkg::IO_REG_OUT};
        end else if (r[31]) begin
            // io tag with a register select that has no register behind it
            a = soc_bus_pkg::IO_BASE | {20'd0, r[11:2], 2'b00};
            a[1:0] = (r[13:12] == 2'd0) ? 2'd1 : r[13:12];
        end else begin
            a = rand32();
            if (a[31:10] == 22'd0) begin
                a[25] = 1'b1;
            end
            if (a[31:12] == soc_bus_pkg::IO_BASE[31:12]) begin
                a[30] = 1'b1;
            end
        end
        return a;
    endfunction

    // reference model of one transfer that queues the expected response
    function automatic void predict_transfer(input logic w, input logic [31:0] a,
                                             input logic [31:0] d, input logic [3:0] m);
        soc_bus_pkg::bus_addr_u au;
        logic [31:0]            rd;
        logic                   e;
        au = a;
        rd = 32'd0;
        e = 1'b0;
        if (au.mem_view.high == '0) begin
            if (w) begin
                shadow_mem[au.mem_view.index] = merge_bytes(shadow_mem[au.mem_view.index], d, m);
            end else begin
                rd = shadow_mem[au.mem_view.index];
            end
        end else if (au.io_view.tag == soc_bus_pkg::IO_BASE[31:12] &&
                     au.io_view.reg_sel == soc_bus_pkg::IO_REG_OUT) begin
            if (w) begin
                shadow_io = merge_bytes(shadow_io, d, m);
            end else begin
                rd = shadow_io;
            end
        end else begin
            e = 1'b1;
        end
        // writes return no data so only reads and errors check rdata
        exp_rd_used_q.push_back(!w || e);
        exp_rdata_q.push_back(rd);
        exp_err_q.push_back(e);
        exp_io_q.push_back(shadow_io);
    endfunction

    task automatic host_transfer(input logic w, input logic [31:0] a, input logic [31:0] d,
                                 input logic [3:0] m, input int stall);
        logic [31:0] held_rdata;
        logic        held_err;
        if (ack !== 1'b0) begin
            abort_run("ack still high when a new request was about to start");
        end
        wen = w;
        addr = a;
        wdata = d;
        wmask = m;
        req = 1'b1;
        do begin
            @(posedge core_clk);
            #1;
        end while (ack !== 1'b1);
        obs_rdata_q.push_back(rdata);
        obs_err_q.push_back(err);
        obs_io_q.push_back(io);
        held_rdata = rdata;
        held_err = err;
        // response must hold while the host stalls
        repeat (stall) begin
            @(posedge core_clk);
            #1;
            if (ack !== 1'b1 || rdata !== held_rdata || err !== held_err) begin
                abort_run("response changed while the host held req high");
            end
        end
        req = 1'b0;
        do begin
            @(posedge core_clk);
            #1;
        end while (ack !== 1'b0);
    endtask

    task automatic run_transfer(input logic w, input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] m);
        int gap;
        int stall;
        gap = rand_below(4);
        stall = rand_below(4);
        repeat (gap) begin
            @(posedge core_clk);
            #1;
        end
        predict_transfer(w, a, d, m);
        host_transfer(w, a, d, m, stall);
    endtask

    always @(negedge core_clk) begin
        if (!rst) begin
            if (ack === 1'b1 && ack_prev === 1'b0 && req_prev !== 1'b1) begin
                abort_run("ack rose while req was low");
            end
            if (ack === 1'b0 && ack_prev === 1'b1 && req_prev === 1'b1) begin
                abort_run("ack fell while req was still high");
            end
        end
        ack_prev <= ack;
        req_prev <= req;
    end

    always @(negedge core_clk) begin : compare
        logic        rd_used;
        logic [31:0] exp_rd;
        while (obs_err_q.size() > 0) begin
            rd_used = exp_rd_used_q.pop_front();
            exp_rd = exp_rdata_q.pop_front();
            if (rd_used) begin
                check_word("rdata", exp_rd, obs_rdata_q.pop_front());
            end else begin
                void'(obs_rdata_q.pop_front());
            end
            check_err("err", exp_err_q.pop_front(), obs_err_q.pop_front());
            check_word("io", exp_io_q.pop_front(), obs_io_q.pop_front());
            checked = checked + 1;
        end
    end

    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the transfers did not finish in the cycle budget");
        end
    end

    initial begin : stimulus
        logic [7:0]  picked [32];
        logic [31:0] r;
        int          kind;
        rst = 1'b1;
        req = 1'b0;
        wen = 1'b0;
        addr = 32'd0;
        wdata = 32'd0;
        wmask = 4'd0;
        repeat (16) @(posedge core_clk);
        #1;
        rst = 1'b0;
        if (ack !== 1'b0) begin
            abort_run("ack is not low after reset");
        end
        check_word("io", 32'd0, io);
        // every word gets a known value before any read
        for (int i = 0; i < soc_bus_pkg::MEM_WORDS; i++) begin
            run_transfer(1'b1, make_addr(0, 8'(i)), rand32(), 4'hf);
        end
        for (int i = 0; i < 32; i++) begin
            r = rand32();
            picked[i] = r[7:0];
            run_transfer(1'b1, make_addr(0, picked[i]), rand32(), r[11:8]);
        end
        for (int i = 0; i < 32; i++) begin
            run_transfer(1'b0, make_addr(0, picked[31 - i]), rand32(), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            run_transfer(1'b1, make_addr(1, 8'd0), rand32(), r[3:0]);
            run_transfer(1'b0, make_addr(1, 8'd0), rand32(), r[7:4]);
        end
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            run_transfer(r[0], make_addr(2, 8'd0), rand32(), r[7:4]);
        end
        // mostly memory with some io and unmapped
        for (int i = 0; i < 200; i++) begin
            r = rand32();
            kind = (r[3:1] < 3'd4) ? 0 : ((r[3:1] < 3'd6) ? 1 : 2);
            run_transfer(r[0], make_addr(kind, r[15:8]), rand32(), r[7:4]);
        end
        @(negedge core_clk);
        @(negedge core_clk);
        if (checked == N_TRANSFERS && exp_err_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("not every transfer was compared against the model");
        end
    end

endmodule

`default_nettype wire

// File: src.f
source/soc_bus_pkg.sv
source/bus_decode.sv
source/bus_execute.sv
source/word_memory.sv
source/parallel_output.sv
source/bus_result.sv
source/soc_bus_top.sv
dv/soc_bus_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the bus subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module soc_bus_tb -Mdir obj_dir -o soc_bus_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/soc_bus_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "simulation finished without the pass message"
exit 1
